// File: axi_adapter.f
+incdir+verilog
verilog/axi_adapter_pkg.sv
verilog/engine_if.sv
verilog/adapter_ctrl.sv
verilog/axi_write_engine.sv
verilog/axi_read_engine.sv
verilog/axi_adapter.sv
test/tb_axi_mem.sv
test/tb_axi_adapter.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f axi_adapter.f --top-module tb_axi_adapter &&
./obj_dir/Vtb_axi_adapter | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: test/tb_axi_adapter.sv
// testbench top for the AXI adapter, runs directed and stress requests against a memory model
`timescale 1ns/1ps

module tb_axi_adapter;
  import axi_adapter_pkg::*;

  localparam int PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int STRESS_COUNT = 40;
  localparam int TEST_COUNT = 5 + STRESS_COUNT;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       clear_i;
  logic       req_i;
  logic       we_i;
  req_type_e  type_i;
  addr_t      addr_i;
  logic [1:0] size_i;
  axi_id_t    id_i;
  line_t      wdata_i;
  line_strb_t be_i;
  logic       gnt_o;
  logic       valid_o;
  logic       busy_o;
  axi_id_t    id_o;
  line_t      rdata_o;
  beat_t      critical_word_o;
  logic       critical_word_valid_o;
  logic       aw_valid_o;
  addr_t      aw_addr_o;
  logic [7:0] aw_len_o;
  logic [2:0] aw_size_o;
  axi_id_t    aw_id_o;
  logic       aw_ready_i;
  logic       w_valid_o;
  beat_t      w_data_o;
  strb_t      w_strb_o;
  logic       w_last_o;
  logic       w_ready_i;
  logic       b_valid_i;
  axi_id_t    b_id_i;
  logic       b_ready_o;
  logic       ar_valid_o;
  addr_t      ar_addr_o;
  logic [7:0] ar_len_o;
  logic [2:0] ar_size_o;
  axi_id_t    ar_id_o;
  logic       ar_ready_i;
  logic       r_valid_i;
  beat_t      r_data_i;
  axi_id_t    r_id_i;
  logic       r_last_i;
  logic       r_ready_o;

  // request slots, filled before a sequence runs
  logic       q_we [64];
  req_type_e  q_typ [64];
  addr_t      q_addr [64];
  axi_id_t    q_id [64];
  line_t      q_wdata [64];
  line_strb_t q_be [64];

  beat_t   ref_mem [256];
  integer  seed;
  int      error_cnt;
  int      monitor_errs = 0;
  logic    in_flight = 1'b0;
  int      crit_cnt = 0;
  beat_t   crit_word = '0;
  axi_id_t got_id;
  line_t   got_line;
  int      got_crit_cnt;
  beat_t   got_crit_word;

  axi_adapter axi_adapter_inst (.*);

  tb_axi_mem tb_mem_inst (
    .clk_i      (clk_i),
    .aw_valid_i (aw_valid_o), .aw_addr_i (aw_addr_o), .aw_len_i (aw_len_o),
    .aw_id_i    (aw_id_o),    .aw_ready_o (aw_ready_i),
    .w_valid_i  (w_valid_o),  .w_data_i (w_data_o),   .w_strb_i (w_strb_o),
    .w_last_i   (w_last_o),   .w_ready_o (w_ready_i),
    .b_valid_o  (b_valid_i),  .b_id_o (b_id_i),       .b_ready_i (b_ready_o),
    .ar_valid_i (ar_valid_o), .ar_addr_i (ar_addr_o), .ar_len_i (ar_len_o),
    .ar_id_i    (ar_id_o),    .ar_ready_o (ar_ready_i),
    .r_valid_o  (r_valid_i),  .r_data_o (r_data_i),   .r_id_o (r_id_i),
    .r_last_o   (r_last_i),   .r_ready_i (r_ready_o)
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  // --------------------
  // requester monitor
  // --------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (in_flight) begin
        assert (busy_o) else begin
          monitor_errs++;
          $display("busy_o went low while a request was in flight at %0t", $time);
        end
      end
      // every beat is 8 bytes wide
      if (aw_valid_o) check_value(64'(aw_size_o), 64'd3, "aw_size_o");
      if (ar_valid_o) check_value(64'(ar_size_o), 64'd3, "ar_size_o");
      if (critical_word_valid_o) begin
        crit_cnt++;
        crit_word = critical_word_o;
      end
      if (valid_o) begin
        assert (in_flight) else begin
          monitor_errs++;
          $display("valid_o pulsed with no granted request at %0t", $time);
        end
        in_flight = 1'b0;
      end
      if (gnt_o) begin
        assert (!in_flight) else begin
          monitor_errs++;
          $display("gnt_o pulsed before the previous request completed at %0t", $time);
        end
        in_flight = 1'b1;
        crit_cnt = 0;
      end
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      error_cnt++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_req(input int k);
    req_i = 1'b1;
    we_i = q_we[k];
    type_i = q_typ[k];
    addr_i = q_addr[k];
    id_i = q_id[k];
    wdata_i = q_wdata[k];
    be_i = q_be[k];
  endtask

  task automatic wait_gnt();
    do begin
      @(negedge clk_i);
    end while (!gnt_o);
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_valid();
    do begin
      @(negedge clk_i);
    end while (!valid_o);
    got_id = id_o;
    got_line = rdata_o;
    got_crit_cnt = crit_cnt;
    got_crit_word = crit_word;
    @(posedge clk_i);
    #2;
  endtask

  // applies byte enables to the reference word and compares the model's copy
  task automatic merge_and_check(input logic [7:0] idx, input beat_t data, input strb_t strb);
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
    check_value(tb_mem_inst.mem[idx], ref_mem[idx], "memory word");
  endtask

  task automatic check_result(input int k);
    logic [7:0] idx;
    check_value(64'(got_id), 64'(q_id[k]), "id_o");
    if (q_we[k]) begin
      check_value(64'(got_crit_cnt), 64'd0, "critical word pulses on a write");
      if (q_typ[k] == SINGLE_REQ) begin
        merge_and_check(q_addr[k][10:3], q_wdata[k][0], q_be[k][0]);
        check_value(64'(tb_mem_inst.last_aw_len), 64'd0, "aw_len");
      end else begin
        for (int i = 0; i < 4; i++) begin
          merge_and_check(q_addr[k][10:3] + 8'(i), q_wdata[k][i], q_be[k][i]);
        end
        check_value(64'(tb_mem_inst.last_aw_len), 64'd3, "aw_len");
      end
    end else begin
      check_value(64'(got_crit_cnt), 64'd1, "critical word pulses");
      if (q_typ[k] == SINGLE_REQ) begin
        idx = q_addr[k][10:3];
        check_value(got_line[0], ref_mem[idx], "rdata_o beat 0");
        check_value(got_crit_word, ref_mem[idx], "critical_word_o");
        check_value(64'(tb_mem_inst.last_ar_addr), 64'(q_addr[k]), "ar_addr");
        check_value(64'(tb_mem_inst.last_ar_len), 64'd0, "ar_len");
      end else begin
        idx = {q_addr[k][10:5], 2'b00};
        for (int i = 0; i < 4; i++) begin
          check_value(got_line[i], ref_mem[idx + 8'(i)], "rdata_o beat");
        end
        check_value(got_crit_word, ref_mem[idx + 8'(q_addr[k][4:3])], "critical_word_o");
        check_value(64'(tb_mem_inst.last_ar_addr), 64'({q_addr[k][31:5], 5'd0}), "ar_addr");
        check_value(64'(tb_mem_inst.last_ar_len), 64'd3, "ar_len");
      end
    end
  endtask

  // the next request is already waiting while the current one is in flight
  task automatic run_sequence(input int n);
    drive_req(0);
    for (int k = 0; k < n; k++) begin
      wait_gnt();
      if (k + 1 < n) drive_req(k + 1);
      else req_i = 1'b0;
      wait_valid();
      check_result(k);
    end
  endtask

  task automatic set_slot(input logic we, input req_type_e typ, input addr_t addr,
                          input axi_id_t id, input line_strb_t be);
    q_we[0] = we;
    q_typ[0] = typ;
    q_addr[0] = addr;
    q_id[0] = id;
    q_be[0] = be;
    for (int b = 0; b < 4; b++) q_wdata[0][b] = {$random(seed), $random(seed)};
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_value(64'(aw_valid_o), 64'd0, "aw_valid_o after reset");
    check_value(64'(w_valid_o), 64'd0, "w_valid_o after reset");
    check_value(64'(w_last_o), 64'd0, "w_last_o after reset");
    check_value(64'(ar_valid_o), 64'd0, "ar_valid_o after reset");
    check_value(64'(b_ready_o), 64'd0, "b_ready_o after reset");
    check_value(64'(r_ready_o), 64'd0, "r_ready_o after reset");
    check_value(64'(gnt_o), 64'd0, "gnt_o after reset");
    check_value(64'(valid_o), 64'd0, "valid_o after reset");
    check_value(64'(critical_word_valid_o), 64'd0, "critical_word_valid_o after reset");
    check_value(64'(busy_o), 64'd0, "busy_o after reset");
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_stress();
    logic [31:0] rnd;
    for (int k = 0; k < STRESS_COUNT; k++) begin
      rnd = $random(seed);
      q_we[k] = rnd[0];
      q_typ[k] = rnd[1] ? LINE_REQ : SINGLE_REQ;
      q_addr[k] = {21'd0, rnd[12:2]};
      // line writes go out as INCR from the given address
      if (rnd[0] && rnd[1]) q_addr[k][4:0] = 5'd0;
      q_id[k] = rnd[19:16];
      q_be[k] = $random(seed);
      for (int b = 0; b < 4; b++) q_wdata[k][b] = {$random(seed), $random(seed)};
    end
    run_sequence(STRESS_COUNT);
  endtask

  initial begin
    #(TEST_COUNT * 200 * PERIOD);
    $display("timeout: the tests did not finish in the expected time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    seed = 32'h398a_a41a;
    error_cnt = 0;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    type_i = SINGLE_REQ;
    addr_i = '0;
    size_i = 2'd3;
    id_i = '0;
    wdata_i = '0;
    be_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < 256; i++) ref_mem[i] = tb_mem_inst.mem[i];
    test_reset();
    set_slot(1'b1, SINGLE_REQ, 32'h0000_0148, 4'h5, {4{8'ha5}});
    run_sequence(1);
    set_slot(1'b1, LINE_REQ, 32'h0000_0260, 4'h9, '1);
    run_sequence(1);
    set_slot(1'b0, SINGLE_REQ, 32'h0000_0148, 4'h3, '0);
    run_sequence(1);
    // word offset 3 inside the line written above
    set_slot(1'b0, LINE_REQ, 32'h0000_0278, 4'hc, '0);
    run_sequence(1);
    test_stress();
    $display("checks done: %0d check errors, %0d monitor errors, %0d model faults",
             error_cnt, monitor_errs, tb_mem_inst.fault_cnt);
    if (error_cnt + monitor_errs + tb_mem_inst.fault_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: test/tb_axi_mem.sv
// AXI slave memory model for the adapter testbench, answers AW/W/B and AR/R with random stalls
`timescale 1ns/1ps

module tb_axi_mem (
  input  logic        clk_i,
  input  logic        aw_valid_i,
  input  logic [31:0] aw_addr_i,
  input  logic [7:0]  aw_len_i,
  input  logic [3:0]  aw_id_i,
  output logic        aw_ready_o,
  input  logic        w_valid_i,
  input  logic [63:0] w_data_i,
  input  logic [7:0]  w_strb_i,
  input  logic        w_last_i,
  output logic        w_ready_o,
  output logic        b_valid_o,
  output logic [3:0]  b_id_o,
  input  logic        b_ready_i,
  input  logic        ar_valid_i,
  input  logic [31:0] ar_addr_i,
  input  logic [7:0]  ar_len_i,
  input  logic [3:0]  ar_id_i,
  output logic        ar_ready_o,
  output logic        r_valid_o,
  output logic [63:0] r_data_o,
  output logic [3:0]  r_id_o,
  output logic        r_last_o,
  input  logic        r_ready_i
);

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic [3:0]  id;
  } cmd_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } wbeat_t;

  logic [63:0] mem [256];
  cmd_t        aw_q [$];
  wbeat_t      w_q [$];
  logic [3:0]  b_q [$];
  cmd_t        ar_q [$];
  cmd_t        cmd;
  wbeat_t      beat;
  logic [7:0]  r_beat;
  logic [7:0]  last_aw_len;
  logic [7:0]  last_ar_len;
  logic [31:0] last_ar_addr;
  logic        b_fire;
  logic        r_fire;
  integer      seed;
  int          fault_cnt;

  task automatic check_len(input logic [7:0] len, input string chan);
    if (len != 8'd0 && len != 8'd3) begin
      fault_cnt++;
      $display("protocol fault at %0t: %s len %0d is neither a single nor a line burst",
               $time, chan, len);
    end
  endtask

  // AW and all its W beats are in, so the burst goes to memory
  task automatic commit_write();
    cmd = aw_q.pop_front();
    for (int i = 0; i <= int'(cmd.len); i++) begin
      beat = w_q.pop_front();
      if (beat.last != (i == int'(cmd.len))) begin
        fault_cnt++;
        $display("protocol fault at %0t: w_last misplaced on beat %0d", $time, i);
      end
      for (int b = 0; b < 8; b++) begin
        if (beat.strb[b]) mem[cmd.addr[10:3] + 8'(i)][8*b +: 8] = beat.data[8*b +: 8];
      end
    end
    b_q.push_back(cmd.id);
  endtask

  initial begin
    seed = 32'h398a_a41a;
    fault_cnt = 0;
    aw_ready_o = 1'b0;
    w_ready_o = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o = 1'b0;
    b_id_o = '0;
    r_valid_o = 1'b0;
    r_data_o = '0;
    r_id_o = '0;
    r_last_o = 1'b0;
    r_beat = '0;
    last_aw_len = '0;
    last_ar_len = '0;
    last_ar_addr = '0;
    // every word differs from every other
    for (int i = 0; i < 256; i++) begin
      mem[i] = {16'(i) ^ 16'ha5c3, 16'(i), 32'(i) * 32'h9e37_79b9};
    end
    forever begin
      // --------------------
      // handshakes, sampled where inputs are stable
      // --------------------
      @(negedge clk_i);
      if (aw_valid_i && aw_ready_o) begin
        aw_q.push_back({aw_addr_i, aw_len_i, aw_id_i});
        last_aw_len = aw_len_i;
        check_len(aw_len_i, "AW");
      end
      if (w_valid_i && w_ready_o) w_q.push_back({w_data_i, w_strb_i, w_last_i});
      if (ar_valid_i && ar_ready_o) begin
        ar_q.push_back({ar_addr_i, ar_len_i, ar_id_i});
        last_ar_addr = ar_addr_i;
        last_ar_len = ar_len_i;
        check_len(ar_len_i, "AR");
      end
      b_fire = b_valid_o && b_ready_i;
      r_fire = r_valid_o && r_ready_i;
      if (aw_q.size() > 0 && w_q.size() > int'(aw_q[0].len)) commit_write();
      // --------------------
      // next cycle outputs
      // --------------------
      @(posedge clk_i);
      #1;
      aw_ready_o = ($random(seed) & 3) != 0;
      w_ready_o = ($random(seed) & 3) != 0;
      ar_ready_o = ($random(seed) & 3) != 0;
      if (b_fire) b_valid_o = 1'b0;
      if (!b_valid_o && b_q.size() > 0 && ($random(seed) & 1) != 0) begin
        b_valid_o = 1'b1;
        b_id_o = b_q.pop_front();
      end
      if (r_fire) begin
        if (r_beat == ar_q[0].len) begin
          ar_q.delete(0);
          r_beat = '0;
        end else begin
          r_beat = r_beat + 8'd1;
        end
        r_valid_o = 1'b0;
        r_last_o = 1'b0;
      end
      if (!r_valid_o && ar_q.size() > 0 && ($random(seed) & 1) != 0) begin
        r_valid_o = 1'b1;
        r_data_o = mem[ar_q[0].addr[10:3] + r_beat];
        r_id_o = ar_q[0].id;
        r_last_o = (r_beat == ar_q[0].len);
      end
    end
  end

endmodule

// File: verilog/axi_adapter.sv
// cache-side AXI4 master adapter top level, connects the controller to the read and write engines
`timescale 1ns/1ps

module axi_adapter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  // requester side
  input  logic                        req_i,
  input  logic                        we_i,
  input  axi_adapter_pkg::req_type_e  type_i,
  input  axi_adapter_pkg::addr_t      addr_i,
  input  logic [1:0]                  size_i,
  input  axi_adapter_pkg::axi_id_t    id_i,
  input  axi_adapter_pkg::line_t      wdata_i,
  input  axi_adapter_pkg::line_strb_t be_i,
  output logic                        gnt_o,
  output logic                        valid_o,
  output logic                        busy_o,
  output axi_adapter_pkg::axi_id_t    id_o,
  output axi_adapter_pkg::line_t      rdata_o,
  output axi_adapter_pkg::beat_t      critical_word_o,
  output logic                        critical_word_valid_o,
  // AW channel
  output logic                        aw_valid_o,
  output axi_adapter_pkg::addr_t      aw_addr_o,
  output logic [7:0]                  aw_len_o,
  output logic [2:0]                  aw_size_o,
  output axi_adapter_pkg::axi_id_t    aw_id_o,
  input  logic                        aw_ready_i,
  // W channel
  output logic                        w_valid_o,
  output axi_adapter_pkg::beat_t      w_data_o,
  output axi_adapter_pkg::strb_t      w_strb_o,
  output logic                        w_last_o,
  input  logic                        w_ready_i,
  // B channel
  input  logic                        b_valid_i,
  input  axi_adapter_pkg::axi_id_t    b_id_i,
  output logic                        b_ready_o,
  // AR channel
  output logic                        ar_valid_o,
  output axi_adapter_pkg::addr_t      ar_addr_o,
  output logic [7:0]                  ar_len_o,
  output logic [2:0]                  ar_size_o,
  output axi_adapter_pkg::axi_id_t    ar_id_o,
  input  logic                        ar_ready_i,
  // R channel
  input  logic                        r_valid_i,
  input  axi_adapter_pkg::beat_t      r_data_i,
  input  axi_adapter_pkg::axi_id_t    r_id_i,
  input  logic                        r_last_i,
  output logic                        r_ready_o
);

  engine_if wr_if ();
  engine_if rd_if ();

  adapter_ctrl adapter_ctrl_inst (
    .wr (wr_if),
    .rd (rd_if),
    .*
  );

  axi_write_engine axi_write_engine_inst (
    .eng (wr_if),
    .*
  );

  axi_read_engine axi_read_engine_inst (
    .eng (rd_if),
    .*
  );

endmodule

// File: verilog/axi_read_engine.sv
// AXI read channel engine, drives AR and R, assembles the line and flags the critical word
`timescale 1ns/1ps
`include "axi_adapter_config.svh"

module axi_read_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  engine_if.engine                   eng,
  input  axi_adapter_pkg::req_type_e type_i,
  input  axi_adapter_pkg::addr_t     addr_i,
  input  logic [1:0]                 size_i,
  input  axi_adapter_pkg::axi_id_t   id_i,
  output logic                       ar_valid_o,
  output axi_adapter_pkg::addr_t     ar_addr_o,
  output logic [7:0]                 ar_len_o,
  output logic [2:0]                 ar_size_o,
  output axi_adapter_pkg::axi_id_t   ar_id_o,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  axi_adapter_pkg::beat_t     r_data_i,
  input  axi_adapter_pkg::axi_id_t   r_id_i,
  input  logic                       r_last_i,
  output logic                       r_ready_o,
  output axi_adapter_pkg::line_t     rdata_o,
  output axi_adapter_pkg::beat_t     critical_word_o,
  output logic                       critical_word_valid_o
);
  import axi_adapter_pkg::*;

  localparam beat_idx_t LAST_IDX = beat_idx_t'(`LINE_BEATS - 1);

  rd_state_e state_q, state_d;
  // index of the next R beat within the line
  beat_idx_t idx_q;
  // requested word inside the line
  beat_idx_t offset_q;
  line_t     line_q;
  axi_id_t   id_q;
  logic      is_line;
  logic      ar_fire;
  logic      r_fire;

  assign is_line = (type_i == LINE_REQ);

  // --------------------
  // AR channel
  // --------------------
  always_comb begin
    ar_addr_o = addr_i;
    // incrementing line bursts start at the line base
    if (is_line) ar_addr_o[`LINE_OFFSET_W-1:0] = '0;
  end

  assign ar_len_o   = is_line ? 8'(`LINE_BEATS - 1) : 8'd0;
  assign ar_size_o  = {1'b0, size_i};
  assign ar_id_o    = id_i;
  assign ar_valid_o = (state_q == R_IDLE) & eng.start;
  assign ar_fire    = ar_valid_o & ar_ready_i;

  // --------------------
  // R channel
  // --------------------
  assign r_ready_o = (state_q == R_WAIT_SINGLE) || (state_q == R_WAIT_LINE);
  assign r_fire    = r_ready_o & r_valid_i;

  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_fire & ((state_q == R_WAIT_SINGLE) || (idx_q == offset_q));

  assign rdata_o    = line_q;
  assign eng.gnt    = ar_fire;
  assign eng.done   = (state_q == R_COMPLETE);
  assign eng.busy   = (state_q != R_IDLE);
  assign eng.rsp_id = id_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      R_IDLE: begin
        if (ar_fire) state_d = is_line ? R_WAIT_LINE : R_WAIT_SINGLE;
      end
      R_WAIT_SINGLE, R_WAIT_LINE: begin
        if (r_fire && r_last_i) state_d = R_COMPLETE;
      end
      R_COMPLETE: state_d = R_IDLE;
      default:    state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= R_IDLE;
      idx_q    <= '0;
      offset_q <= '0;
    end else if (clear_i) begin
      state_q  <= R_IDLE;
      idx_q    <= '0;
      offset_q <= '0;
    end else begin
      state_q <= state_d;
      if (ar_fire) begin
        idx_q    <= '0;
        offset_q <= addr_i[`BEAT_OFFSET_W +: `BEAT_IDX_W];
      end else if (r_fire) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // line data and response ID
  always_ff @(posedge clk_i) begin
    if (r_fire) line_q[idx_q] <= r_data_i;
    if (r_fire && r_last_i) id_q <= r_id_i;
  end

  // slave ends a line burst on exactly the fourth beat
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (state_q == R_WAIT_LINE) && r_fire |-> r_last_i == (idx_q == LAST_IDX));

endmodule

// File: verilog/axi_write_engine.sv
// AXI write channel engine, drives AW, W and B for single and cache-line writes
`timescale 1ns/1ps
`include "axi_adapter_config.svh"

module axi_write_engine (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  engine_if.engine                    eng,
  input  axi_adapter_pkg::req_type_e  type_i,
  input  axi_adapter_pkg::addr_t      addr_i,
  input  logic [1:0]                  size_i,
  input  axi_adapter_pkg::axi_id_t    id_i,
  input  axi_adapter_pkg::line_t      wdata_i,
  input  axi_adapter_pkg::line_strb_t be_i,
  output logic                        aw_valid_o,
  output axi_adapter_pkg::addr_t      aw_addr_o,
  output logic [7:0]                  aw_len_o,
  output logic [2:0]                  aw_size_o,
  output axi_adapter_pkg::axi_id_t    aw_id_o,
  input  logic                        aw_ready_i,
  output logic                        w_valid_o,
  output axi_adapter_pkg::beat_t      w_data_o,
  output axi_adapter_pkg::strb_t      w_strb_o,
  output logic                        w_last_o,
  input  logic                        w_ready_i,
  input  logic                        b_valid_i,
  input  axi_adapter_pkg::axi_id_t    b_id_i,
  output logic                        b_ready_o
);
  import axi_adapter_pkg::*;

  localparam beat_idx_t LAST_IDX = beat_idx_t'(`LINE_BEATS - 1);

  wr_state_e state_q, state_d;
  // W beats left after the current one
  beat_idx_t cnt_q, cnt_d;
  beat_idx_t beat_sel;
  axi_id_t   id_q;
  logic      is_line;
  logic      last_beat;

  assign is_line   = (type_i == LINE_REQ);
  assign last_beat = !is_line || (cnt_q == '0);
  assign beat_sel  = is_line ? LAST_IDX - cnt_q : '0;

  // --------------------
  // AW and W payload
  // --------------------
  assign aw_addr_o = addr_i;
  assign aw_len_o  = is_line ? 8'(`LINE_BEATS - 1) : 8'd0;
  assign aw_size_o = {1'b0, size_i};
  assign aw_id_o   = id_i;
  assign w_data_o  = wdata_i[beat_sel];
  assign w_strb_o  = be_i[beat_sel];
  assign w_last_o  = w_valid_o & last_beat;

  assign eng.busy   = (state_q != W_IDLE);
  assign eng.rsp_id = b_id_i;

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    eng.gnt    = 1'b0;
    eng.done   = 1'b0;
    case (state_q)
      W_IDLE: begin
        if (eng.start) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (!is_line) begin
            // grant right away when both channels take it
            eng.gnt = aw_ready_i & w_ready_i;
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = W_WAIT_B;
              2'b01:   state_d = W_WAIT_AW;
              2'b10:   state_d = W_WAIT_LAST_W;
              default: state_d = W_IDLE;
            endcase
          end else begin
            if (w_ready_i) cnt_d = cnt_q - 1'b1;
            case ({aw_ready_i, w_ready_i})
              2'b11, 2'b10: state_d = W_WAIT_LAST_W;
              2'b01:        state_d = W_WAIT_W_AND_AW;
              default:      state_d = W_IDLE;
            endcase
          end
        end
      end
      W_WAIT_AW, W_WAIT_AW_BURST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          eng.gnt = 1'b1;
          state_d = W_WAIT_B;
        end
      end
      W_WAIT_LAST_W: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (last_beat) begin
            eng.gnt = 1'b1;
            state_d = W_WAIT_B;
          end else begin
            cnt_d = cnt_q - 1'b1;
          end
        end
      end
      W_WAIT_W_AND_AW: begin
        // line burst with AW still pending
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        case ({aw_ready_i, w_ready_i})
          2'b01: begin
            if (last_beat) state_d = W_WAIT_AW_BURST;
            else cnt_d = cnt_q - 1'b1;
          end
          2'b10: state_d = W_WAIT_LAST_W;
          2'b11: begin
            if (last_beat) begin
              eng.gnt = 1'b1;
              state_d = W_WAIT_B;
            end else begin
              cnt_d   = cnt_q - 1'b1;
              state_d = W_WAIT_LAST_W;
            end
          end
          default: ;
        endcase
      end
      W_WAIT_B: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          eng.done = 1'b1;
          cnt_d    = LAST_IDX;
          state_d  = W_IDLE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
      cnt_q   <= LAST_IDX;
    end else if (clear_i) begin
      state_q <= W_IDLE;
      cnt_q   <= LAST_IDX;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ID of the accepted AW, compared against the B response
  always_ff @(posedge clk_i) begin
    if (aw_valid_o && aw_ready_i) id_q <= id_i;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    w_valid_o && !w_ready_i |=> w_valid_o);

  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    b_valid_i && b_ready_o |-> b_id_i == id_q);

endmodule

// File: verilog/adapter_ctrl.sv
// routes requester traffic to the read or write engine and merges their status
`timescale 1ns/1ps

module adapter_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     req_i,
  input  logic                     we_i,
  output logic                     gnt_o,
  output logic                     valid_o,
  output logic                     busy_o,
  output axi_adapter_pkg::axi_id_t id_o,
  engine_if.ctrl                   wr,
  engine_if.ctrl                   rd
);
  import axi_adapter_pkg::*;

  path_e path_q, path_d;

  // engine busy covers the first cycle before the path register follows
  assign busy_o = (path_q != PATH_IDLE) | wr.busy | rd.busy;

  // new requests only while nothing is in flight
  assign wr.start = req_i & we_i & ~busy_o;
  assign rd.start = req_i & ~we_i & ~busy_o;

  assign gnt_o   = wr.gnt | rd.gnt;
  assign valid_o = wr.done | rd.done;
  assign id_o    = wr.done ? wr.rsp_id : rd.rsp_id;

  always_comb begin
    path_d = path_q;
    case (path_q)
      PATH_IDLE: begin
        // a write may already complete in its first busy cycle
        if (wr.busy && !wr.done) begin
          path_d = PATH_WRITE;
        end else if (rd.busy && !rd.done) begin
          path_d = PATH_READ;
        end
      end
      PATH_WRITE: if (wr.done) path_d = PATH_IDLE;
      PATH_READ:  if (rd.done) path_d = PATH_IDLE;
      default:    path_d = PATH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      path_q <= PATH_IDLE;
    end else if (clear_i) begin
      path_q <= PATH_IDLE;
    end else begin
      path_q <= path_d;
    end
  end

  // one request in flight, so the engines never overlap
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr.busy && rd.busy));

endmodule

// File: verilog/engine_if.sv
// request and status handshake between the adapter controller and one AXI channel engine
`timescale 1ns/1ps

interface engine_if;
  import axi_adapter_pkg::*;

  // request routed to this engine, a level
  logic start;
  // request taken
  logic gnt;
  // one-cycle completion
  logic done;
  // engine out of idle
  logic busy;
  // response ID, valid with done
  axi_id_t rsp_id;

  modport ctrl (
    output start,
    input  gnt, done, busy, rsp_id
  );

  modport engine (
    input  start,
    output gnt, done, busy, rsp_id
  );

endinterface

// File: verilog/axi_adapter_pkg.sv
// shared data, address and ID types plus FSM state enums of the AXI adapter
`include "axi_adapter_config.svh"

package axi_adapter_pkg;

  typedef logic [`AXI_DATA_W-1:0] beat_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef beat_t [`LINE_BEATS-1:0] line_t;
  typedef strb_t [`LINE_BEATS-1:0] line_strb_t;
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_ID_W-1:0] axi_id_t;
  typedef logic [`BEAT_IDX_W-1:0] beat_idx_t;

  typedef enum logic {SINGLE_REQ, LINE_REQ} req_type_e;

  typedef enum logic [1:0] {PATH_IDLE, PATH_WRITE, PATH_READ} path_e;

  // write side waits on AW, W and B in any order the slave picks
  typedef enum logic [2:0] {
    W_IDLE, W_WAIT_AW, W_WAIT_LAST_W, W_WAIT_W_AND_AW, W_WAIT_AW_BURST, W_WAIT_B
  } wr_state_e;

  typedef enum logic [1:0] {R_IDLE, R_WAIT_SINGLE, R_WAIT_LINE, R_COMPLETE} rd_state_e;

endpackage

// File: verilog/axi_adapter_config.svh
// bus widths and cache-line geometry, included by the adapter package and RTL
`ifndef AXI_ADAPTER_CONFIG_SVH
`define AXI_ADAPTER_CONFIG_SVH

// --------------------
// AXI bus widths
// --------------------
`define AXI_DATA_W 64
`define AXI_ADDR_W 32
`define AXI_ID_W 4

// --------------------
// cache line geometry
// --------------------
// four 64-bit beats per line
`define LINE_BEATS 4
`define BEAT_IDX_W 2
`define LINE_OFFSET_W 5
`define BEAT_OFFSET_W 3

`endif
